// ==== pe_weight_pkg.sv ====
`default_nettype none

package pe_weight_pkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int lane_w = 8;
   localparam int word_w = 32;
   localparam int sum_w  = 24;

   // four lanes per word, lane 0 in the low byte
   typedef logic [word_w-1:0] weight_word_t;

   // one weight or one activation
   typedef logic signed [lane_w-1:0] lane_t;

   // one row's dot product
   typedef logic signed [sum_w-1:0] sum_t;

   // ------------------------------------------------------------------------
   // state and mode encodings
   // ------------------------------------------------------------------------
   typedef enum logic {
      mode_dw = 1'b0,
      mode_pw = 1'b1
   } conv_mode_t;

   typedef enum logic {
      load_idle,
      load_busy
   } load_state_t;

   // config register map
   localparam logic [1:0] cfg_addr_mode  = 2'd0;
   localparam logic [1:0] cfg_addr_rows  = 2'd1;
   localparam logic [1:0] cfg_addr_words = 2'd2;
   localparam logic [1:0] cfg_addr_start = 2'd3;

endpackage

`default_nettype wire

// ==== weight_cfg_regs.sv ====
`default_nettype none

module weight_cfg_regs #(
   parameter int num_rows  = 9,
   parameter int row_words = 4
) (
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire logic                             cfg_we,
   input  wire logic [1:0]                       cfg_addr,
   input  wire logic [7:0]                       cfg_wdata,
   output pe_weight_pkg::conv_mode_t             mode,
   output logic [$clog2(num_rows + 1)-1:0]       rows_used,
   output logic [$clog2(row_words + 1)-1:0]      words_per_row,
   output logic                                  start
);

   localparam int rows_w  = $clog2(num_rows + 1);
   localparam int words_w = $clog2(row_words + 1);

   // settings are levels, start is a one-cycle pulse
   always_ff @(posedge clk) begin
      if (reset) begin
         mode          <= pe_weight_pkg::mode_pw;
         rows_used     <= rows_w'(num_rows);
         words_per_row <= words_w'(row_words);
         start         <= 1'b0;
      end else begin
         start <= 1'b0;
         if (cfg_we) begin
            case (cfg_addr)
               pe_weight_pkg::cfg_addr_mode: begin
                  mode <= pe_weight_pkg::conv_mode_t'(cfg_wdata[0]);
               end
               pe_weight_pkg::cfg_addr_rows: begin
                  rows_used <= cfg_wdata[rows_w-1:0];
               end
               pe_weight_pkg::cfg_addr_words: begin
                  words_per_row <= cfg_wdata[words_w-1:0];
               end
               pe_weight_pkg::cfg_addr_start: begin
                  // data ignored, the write itself is the command
                  start <= 1'b1;
               end
               default: begin
                  start <= 1'b0;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== weight_load_ctrl.sv ====
`default_nettype none

module weight_load_ctrl #(
   parameter int num_rows  = 9,
   parameter int row_words = 4
) (
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire logic                             start,
   input  wire pe_weight_pkg::conv_mode_t        mode,
   input  wire logic [$clog2(num_rows + 1)-1:0]  rows_used,
   input  wire logic [$clog2(row_words + 1)-1:0] words_per_row,
   input  wire logic                             weight_valid,
   output logic                                  weight_ready,
   output logic                                  wr_en,
   output logic [$clog2(num_rows + 1)-1:0]       wr_row,
   output logic [$clog2(row_words + 1)-1:0]      wr_word,
   output logic                                  load_done
);

   localparam int rows_w  = $clog2(num_rows + 1);
   localparam int words_w = $clog2(row_words + 1);

   pe_weight_pkg::load_state_t state;

   logic [rows_w-1:0]  row_cnt;
   logic [words_w-1:0] word_cnt;
   logic               accept;
   logic               row_end;
   logic               last_word;

   // ------------------------------------------------------------------------
   // handshake and end-of-load detect
   // ------------------------------------------------------------------------
   assign weight_ready = (state == pe_weight_pkg::load_busy);
   assign accept       = weight_valid && weight_ready;

   // DW loads one word per row, always at word 0
   assign row_end   = (mode == pe_weight_pkg::mode_dw) ||
                      (word_cnt == words_per_row - 1'b1);
   assign last_word = row_end && (row_cnt == rows_used - 1'b1);

   assign wr_en     = accept;
   assign wr_row    = row_cnt;
   assign wr_word   = word_cnt;
   assign load_done = accept && last_word;

   // ------------------------------------------------------------------------
   // state machine and counters
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= pe_weight_pkg::load_idle;
         row_cnt  <= '0;
         word_cnt <= '0;
      end else if (start) begin
         // restart from the first position, even mid-load
         state    <= pe_weight_pkg::load_busy;
         row_cnt  <= '0;
         word_cnt <= '0;
      end else if (accept) begin
         if (last_word) begin
            state    <= pe_weight_pkg::load_idle;
            row_cnt  <= '0;
            word_cnt <= '0;
         end else if (row_end) begin
            row_cnt  <= row_cnt + 1'b1;
            word_cnt <= '0;
         end else begin
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== weight_buffer.sv ====
`default_nettype none

module weight_buffer #(
   parameter int num_rows  = 9,
   parameter int row_words = 4
) (
   input  wire logic                                             clk,
   input  wire logic                                             reset,
   input  wire logic                                             clear,
   input  wire pe_weight_pkg::conv_mode_t                        mode,
   input  wire logic                                             wr_en,
   input  wire logic [$clog2(num_rows + 1)-1:0]                  wr_row,
   input  wire logic [$clog2(row_words + 1)-1:0]                 wr_word,
   input  wire pe_weight_pkg::weight_word_t                      weight_in,
   output logic [num_rows*row_words*pe_weight_pkg::word_w-1:0]   weight_out
);

   localparam int rows_w        = $clog2(num_rows + 1);
   localparam int words_w       = $clog2(row_words + 1);
   localparam int lane_w        = pe_weight_pkg::lane_w;
   localparam int lanes_per_wrd = pe_weight_pkg::word_w / lane_w;
   localparam int lanes         = row_words * lanes_per_wrd;

   pe_weight_pkg::weight_word_t mem [num_rows][row_words];

   // ------------------------------------------------------------------------
   // storage
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         for (int r = 0; r < num_rows; r++) begin
            for (int w = 0; w < row_words; w++) begin
               mem[r][w] <= '0;
            end
         end
      end else if (wr_en) begin
         // positions outside the array are dropped
         for (int r = 0; r < num_rows; r++) begin
            for (int w = 0; w < row_words; w++) begin
               if (wr_row == rows_w'(r) && wr_word == words_w'(w)) begin
                  mem[r][w] <= weight_in;
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // output layout, one lane at a time
   // ------------------------------------------------------------------------
   for (genvar r = 0; r < num_rows; r++) begin : g_row
      localparam int grp = r / 3;
      localparam int k   = r % 3;

      for (genvar l = 0; l < lanes; l++) begin : g_lane
         pe_weight_pkg::lane_t pw_lane;
         pe_weight_pkg::lane_t dw_lane;

         // PW: lane l is byte (l mod 4) of word (l div 4)
         assign pw_lane = mem[r][l / lanes_per_wrd][(l % lanes_per_wrd)*lane_w +: lane_w];

         // DW: 3-lane diagonal per group, lane 3g+j from stored row 3g+j
         if (l >= 3*grp && l < 3*grp + 3) begin : g_dw_tap
            assign dw_lane = mem[l][0][k*lane_w +: lane_w];
         end else begin : g_dw_zero
            assign dw_lane = '0;
         end

         assign weight_out[(r*lanes + l)*lane_w +: lane_w] =
            (mode == pe_weight_pkg::mode_pw) ? pw_lane : dw_lane;
      end
   end

endmodule

`default_nettype wire

// ==== pe_row_mac.sv ====
`default_nettype none

module pe_row_mac #(
   parameter int num_rows  = 9,
   parameter int row_words = 4
) (
   input  wire logic                                             clk,
   input  wire logic                                             reset,
   input  wire logic [num_rows*row_words*pe_weight_pkg::word_w-1:0] weight_rows,
   input  wire logic                                             act_valid,
   input  wire logic [row_words*pe_weight_pkg::word_w-1:0]       act_vec,
   output logic                                                  sum_valid,
   output pe_weight_pkg::sum_t [num_rows-1:0]                    row_sums
);

   localparam int lane_w = pe_weight_pkg::lane_w;
   localparam int lanes  = row_words * (pe_weight_pkg::word_w / lane_w);

   pe_weight_pkg::sum_t dot [num_rows];

   // ------------------------------------------------------------------------
   // per-row signed dot product against the broadcast activations
   // ------------------------------------------------------------------------
   for (genvar r = 0; r < num_rows; r++) begin : g_row
      always_comb begin
         pe_weight_pkg::sum_t  acc;
         pe_weight_pkg::lane_t w;
         pe_weight_pkg::lane_t a;
         acc = '0;
         for (int l = 0; l < lanes; l++) begin
            w   = weight_rows[(r*lanes + l)*lane_w +: lane_w];
            a   = act_vec[l*lane_w +: lane_w];
            acc = acc + w * a;
         end
         dot[r] = acc;
      end
   end

   // ------------------------------------------------------------------------
   // output register, one result per cycle
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         sum_valid <= 1'b0;
      end else begin
         sum_valid <= act_valid;
      end
   end

   // sums only move when a new vector arrives
   always_ff @(posedge clk) begin
      if (act_valid) begin
         for (int r = 0; r < num_rows; r++) begin
            row_sums[r] <= dot[r];
         end
      end
   end

endmodule

`default_nettype wire

// ==== weight_path_top.sv ====
`default_nettype none

module weight_path_top #(
   parameter int num_rows  = 9,
   parameter int row_words = 4
) (
   input  wire logic                                  clk,
   input  wire logic                                  reset,
   input  wire logic                                  cfg_we,
   input  wire logic [1:0]                            cfg_addr,
   input  wire logic [7:0]                            cfg_wdata,
   input  wire logic                                  weight_valid,
   input  wire pe_weight_pkg::weight_word_t           weight_in,
   output wire logic                                  weight_ready,
   output wire logic                                  load_done,
   input  wire logic                                  act_valid,
   input  wire logic [row_words*pe_weight_pkg::word_w-1:0] act_vec,
   output wire logic                                  sum_valid,
   output pe_weight_pkg::sum_t [num_rows-1:0]         row_sums
);

   localparam int rows_w  = $clog2(num_rows + 1);
   localparam int words_w = $clog2(row_words + 1);

   pe_weight_pkg::conv_mode_t mode;

   logic [rows_w-1:0]  rows_used;
   logic [words_w-1:0] words_per_row;
   logic               start;
   logic               wr_en;
   logic [rows_w-1:0]  wr_row;
   logic [words_w-1:0] wr_word;
   logic [num_rows*row_words*pe_weight_pkg::word_w-1:0] weight_out;

   weight_cfg_regs #(.num_rows(num_rows), .row_words(row_words)) u_cfg (
      .clk(clk), .reset(reset),
      .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
      .mode(mode), .rows_used(rows_used), .words_per_row(words_per_row),
      .start(start)
   );

   weight_load_ctrl #(.num_rows(num_rows), .row_words(row_words)) u_ctrl (
      .clk(clk), .reset(reset), .start(start),
      .mode(mode), .rows_used(rows_used), .words_per_row(words_per_row),
      .weight_valid(weight_valid), .weight_ready(weight_ready),
      .wr_en(wr_en), .wr_row(wr_row), .wr_word(wr_word), .load_done(load_done)
   );

   // start also wipes the previous weights
   weight_buffer #(.num_rows(num_rows), .row_words(row_words)) u_buf (
      .clk(clk), .reset(reset), .clear(start), .mode(mode),
      .wr_en(wr_en), .wr_row(wr_row), .wr_word(wr_word),
      .weight_in(weight_in), .weight_out(weight_out)
   );

   pe_row_mac #(.num_rows(num_rows), .row_words(row_words)) u_mac (
      .clk(clk), .reset(reset), .weight_rows(weight_out),
      .act_valid(act_valid), .act_vec(act_vec),
      .sum_valid(sum_valid), .row_sums(row_sums)
   );

endmodule

`default_nettype wire

// ==== tb_weight_path.sv ====
`default_nettype none

module tb_weight_path;

   localparam int num_rows    = 9;
   localparam int row_words   = 4;
   localparam int lanes       = row_words * 4;
   localparam int cycle_limit = 4000;

   logic                                clk;
   logic                                reset;
   logic                                cfg_we;
   logic [1:0]                          cfg_addr;
   logic [7:0]                          cfg_wdata;
   logic                                weight_valid;
   pe_weight_pkg::weight_word_t         weight_in;
   logic                                weight_ready;
   logic                                load_done;
   logic                                act_valid;
   logic [lanes*8-1:0]                  act_vec;
   logic                                sum_valid;
   pe_weight_pkg::sum_t [num_rows-1:0]  row_sums;

   // reference copy of the stored words and the settings
   pe_weight_pkg::weight_word_t model_mem [num_rows][row_words];
   logic model_pw;
   int   model_rows;
   int   model_words;
   int   cycle_cnt;

   weight_path_top #(.num_rows(num_rows), .row_words(row_words)) dut (
      .clk(clk), .reset(reset),
      .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
      .weight_valid(weight_valid), .weight_in(weight_in),
      .weight_ready(weight_ready), .load_done(load_done),
      .act_valid(act_valid), .act_vec(act_vec),
      .sum_valid(sum_valid), .row_sums(row_sums)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("*** TEST FAILED ***");
         $fatal(1, "timeout");
      end
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------

   // next edge, then the drive point
   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic fail_check(input string msg);
      $display("Fail at time %0t: %s", $time, msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at first error");
   endtask

   task automatic clear_model();
      for (int r = 0; r < num_rows; r++) begin
         for (int w = 0; w < row_words; w++) begin
            model_mem[r][w] = '0;
         end
      end
   endtask

   // weight seen by PE row r on lane l
   function automatic pe_weight_pkg::lane_t model_lane(input int r, input int l);
      pe_weight_pkg::weight_word_t w;
      int g;
      int k;
      g = r / 3;
      k = r % 3;
      if (model_pw) begin
         w = model_mem[r][l / 4];
         return w[(l % 4)*8 +: 8];
      end
      // DW diagonal, lane 3g+j comes from stored row 3g+j
      if (l >= 3*g && l < 3*g + 3) begin
         w = model_mem[l][0];
         return w[k*8 +: 8];
      end
      return '0;
   endfunction

   function automatic pe_weight_pkg::sum_t model_dot(input int r,
                                                     input logic [lanes*8-1:0] vec);
      int acc;
      pe_weight_pkg::lane_t a;
      acc = 0;
      for (int l = 0; l < lanes; l++) begin
         a   = vec[l*8 +: 8];
         acc = acc + int'(model_lane(r, l)) * int'(a);
      end
      return pe_weight_pkg::sum_t'(acc);
   endfunction

   function automatic logic [lanes*8-1:0] random_act_vec();
      logic [lanes*8-1:0] vec;
      for (int i = 0; i < lanes / 4; i++) begin
         vec[i*32 +: 32] = $urandom();
      end
      return vec;
   endfunction

   task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      step();
      cfg_we = 1'b0;
      case (addr)
         pe_weight_pkg::cfg_addr_mode:  model_pw    = data[0];
         pe_weight_pkg::cfg_addr_rows:  model_rows  = int'(data);
         pe_weight_pkg::cfg_addr_words: model_words = int'(data);
         default: ;
      endcase
   endtask

   // start pulse on the first edge, busy on the second
   task automatic start_load();
      cfg_we    = 1'b1;
      cfg_addr  = pe_weight_pkg::cfg_addr_start;
      cfg_wdata = 8'h00;
      step();
      cfg_we = 1'b0;
      clear_model();
      assert (weight_ready === 1'b0)
         else fail_check("weight_ready high one cycle after the start write");
      step();
      assert (weight_ready === 1'b1)
         else fail_check("weight_ready low two cycles after the start write");
   endtask

   task automatic load_words();
      pe_weight_pkg::weight_word_t data;
      int total;
      int row;
      int word;
      total = model_pw ? model_rows * model_words : model_rows;
      row   = 0;
      word  = 0;
      for (int n = 0; n < total; n++) begin
         data         = $urandom();
         weight_in    = data;
         weight_valid = 1'b1;
         // look at the handshake mid-cycle
         #8;
         assert (weight_ready === 1'b1)
            else fail_check($sformatf("weight_ready low at word %0d", n));
         assert (load_done === (n == total - 1))
            else fail_check($sformatf("load_done is %b at word %0d of %0d",
                                      load_done, n, total));
         step();
         model_mem[row][word] = data;
         if (!model_pw || word == model_words - 1) begin
            row  = row + 1;
            word = 0;
         end else begin
            word = word + 1;
         end
      end
      weight_valid = 1'b0;
      assert (weight_ready === 1'b0)
         else fail_check("weight_ready still high after the last word");
   endtask

   // one-hot activation per lane reads back each weight
   task automatic check_layout(input string tag);
      pe_weight_pkg::lane_t expect_lane;
      for (int l = 0; l < lanes; l++) begin
         act_vec            = '0;
         act_vec[l*8 +: 8]  = 8'd1;
         act_valid          = 1'b1;
         step();
         act_valid = 1'b0;
         assert (sum_valid === 1'b1)
            else fail_check($sformatf("%s: sum_valid low for lane %0d", tag, l));
         for (int r = 0; r < num_rows; r++) begin
            expect_lane = model_lane(r, l);
            assert (row_sums[r] === pe_weight_pkg::sum_t'(expect_lane))
               else fail_check($sformatf("%s: row %0d lane %0d is %0d, expected %0d",
                                         tag, r, l, row_sums[r], expect_lane));
         end
      end
   endtask

   // back-to-back vectors, one result per cycle
   task automatic run_random_acts(input int count, input string tag);
      logic [lanes*8-1:0]  vec;
      pe_weight_pkg::sum_t expect_sum;
      for (int i = 0; i < count; i++) begin
         vec       = random_act_vec();
         act_vec   = vec;
         act_valid = 1'b1;
         step();
         assert (sum_valid === 1'b1)
            else fail_check($sformatf("%s: sum_valid low for vector %0d", tag, i));
         for (int r = 0; r < num_rows; r++) begin
            expect_sum = model_dot(r, vec);
            assert (row_sums[r] === expect_sum)
               else fail_check($sformatf("%s: vector %0d row %0d sum %0d, expected %0d",
                                         tag, i, r, row_sums[r], expect_sum));
         end
      end
      act_valid = 1'b0;
      step();
      assert (sum_valid === 1'b0)
         else fail_check($sformatf("%s: sum_valid stuck high", tag));
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------

   task automatic test_reset_state();
      assert (weight_ready === 1'b0) else fail_check("weight_ready high after reset");
      assert (load_done === 1'b0) else fail_check("load_done high after reset");
      assert (sum_valid === 1'b0) else fail_check("sum_valid high after reset");
      act_vec   = random_act_vec();
      act_valid = 1'b1;
      step();
      act_valid = 1'b0;
      assert (sum_valid === 1'b1) else fail_check("sum_valid low after reset vector");
      for (int r = 0; r < num_rows; r++) begin
         assert (row_sums[r] === '0)
            else fail_check($sformatf("row %0d sum %0d after reset", r, row_sums[r]));
      end
      step();
      assert (sum_valid === 1'b0) else fail_check("sum_valid held past one cycle");
   endtask

   task automatic test_pw_load();
      cfg_write(pe_weight_pkg::cfg_addr_mode, 8'h01);
      cfg_write(pe_weight_pkg::cfg_addr_rows, 8'(num_rows));
      cfg_write(pe_weight_pkg::cfg_addr_words, 8'(row_words));
      start_load();
      load_words();
      check_layout("pw");
      run_random_acts(400, "pw random");
   endtask

   task automatic test_dw_load();
      cfg_write(pe_weight_pkg::cfg_addr_mode, 8'h00);
      cfg_write(pe_weight_pkg::cfg_addr_rows, 8'(num_rows));
      start_load();
      load_words();
      check_layout("dw");
      run_random_acts(200, "dw random");
   endtask

   task automatic test_ignored_and_clear();
      // controller is idle, stray words must not land
      for (int i = 0; i < 8; i++) begin
         weight_in    = $urandom();
         weight_valid = 1'b1;
         #8;
         assert (weight_ready === 1'b0) else fail_check("weight_ready high while idle");
         assert (load_done === 1'b0) else fail_check("load_done on a stray word");
         step();
      end
      weight_valid = 1'b0;
      check_layout("dw after stray words");
      // partial load, rows 3 to 8 stay empty
      cfg_write(pe_weight_pkg::cfg_addr_mode, 8'h01);
      cfg_write(pe_weight_pkg::cfg_addr_rows, 8'd3);
      cfg_write(pe_weight_pkg::cfg_addr_words, 8'd2);
      start_load();
      load_words();
      check_layout("partial pw");
      run_random_acts(100, "partial pw random");
      start_load();
      check_layout("after clear");
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      void'($urandom(32'h98ae_4dfd));
      clk          = 1'b0;
      reset        = 1'b1;
      cfg_we       = 1'b0;
      cfg_addr     = '0;
      cfg_wdata    = '0;
      weight_valid = 1'b0;
      weight_in    = '0;
      act_valid    = 1'b0;
      act_vec      = '0;
      cycle_cnt    = 0;
      clear_model();
      model_pw    = 1'b1;
      model_rows  = num_rows;
      model_words = row_words;
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;

      test_reset_state();
      test_pw_load();
      test_dw_load();
      test_ignored_and_clear();

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== weight_path_top.f ====
pe_weight_pkg.sv
weight_cfg_regs.sv
weight_load_ctrl.sv
weight_buffer.sv
pe_row_mac.sv
weight_path_top.sv
tb_weight_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the weight path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_weight_path -f weight_path_top.f \
   -o sim_weight_path > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_weight_path > sim.log 2>&1

grep -qF "*** TEST FAILED ***" sim.log \
   && { echo "simulation failed, see sim.log"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log \
   && { echo "simulation passed"; exit 0; }
echo "no result found in sim.log"
exit 1
